//--- hw/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] rv32i_word;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } rv32i_opcode;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,   // zero so a cleared word is harmless
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_ops;

    typedef enum logic {
        alumux1_rs1 = 1'b0,
        alumux1_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [1:0] {
        alumux2_rs2   = 2'd0,
        alumux2_i_imm = 2'd1,
        alumux2_s_imm = 2'd2,
        alumux2_u_imm = 2'd3
    } alumux2_sel_t;

    typedef enum logic [1:0] {
        rf_alu_out = 2'd0,
        rf_cmp     = 2'd1,
        rf_u_imm   = 2'd2,
        rf_load    = 2'd3
    } regfilemux_sel_t;

    typedef struct packed {
        alu_ops          aluop;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        regfilemux_sel_t regfilemux_sel;
        logic            load_regfile;
        logic            mem_read;
        logic            mem_write;
        logic [2:0]      funct3;   // access size and signedness
    } control_word;

    typedef struct packed {
        control_word ctrl;
        rv32i_word   pc;
        rv32i_word   rs1_data;
        rv32i_word   rs2_data;
        rv32i_word   imm;   // immediate picked in ID
        rv32i_word   u_imm;
        logic [4:0]  rd;
    } id_ex_t;

    typedef struct packed {
        control_word ctrl;
        rv32i_word   alu_out;
        logic        cmp;
        rv32i_word   store_data;
        rv32i_word   u_imm;   // rides along for lui writeback
        logic [4:0]  rd;
    } ex_mem_t;

    typedef struct packed {
        control_word ctrl;
        rv32i_word   alu_out;
        logic        cmp;
        rv32i_word   load_word;   // raw word, aligned in WB
        logic [1:0]  addr_lo;
        rv32i_word   u_imm;
        logic [4:0]  rd;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- hw/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import rv32i_pkg::*; (
    input  rv32i_word   i_instr,
    output control_word o_ctrl
);

    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic        funct7_5;
    alu_ops      arith_op;   // shared by op and op_imm

    assign opcode   = rv32i_opcode'(i_instr[6:0]);
    assign funct3   = i_instr[14:12];
    assign funct7_5 = i_instr[30];   // sub / sra select

    always_comb begin
        case (funct3)
            3'b000:  arith_op = alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = funct7_5 ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        o_ctrl = '0;   // anything unknown decodes as a nop
        case (opcode)
            op_reg: begin
                o_ctrl.aluop          = (funct3 == 3'b000 && funct7_5) ? alu_sub : arith_op;
                o_ctrl.alumux2_sel    = alumux2_rs2;
                o_ctrl.regfilemux_sel = (funct3[2:1] == 2'b01) ? rf_cmp : rf_alu_out;
                o_ctrl.load_regfile   = 1'b1;
            end
            op_imm: begin
                o_ctrl.aluop          = arith_op;   // no subi, so bit 30 only matters for shifts
                o_ctrl.alumux2_sel    = alumux2_i_imm;
                o_ctrl.regfilemux_sel = (funct3[2:1] == 2'b01) ? rf_cmp : rf_alu_out;
                o_ctrl.load_regfile   = 1'b1;
            end
            op_lui: begin
                o_ctrl.alumux2_sel    = alumux2_u_imm;
                o_ctrl.regfilemux_sel = rf_u_imm;
                o_ctrl.load_regfile   = 1'b1;
            end
            op_auipc: begin
                o_ctrl.alumux1_sel    = alumux1_pc;
                o_ctrl.alumux2_sel    = alumux2_u_imm;
                o_ctrl.load_regfile   = 1'b1;
            end
            op_load: begin
                o_ctrl.alumux2_sel    = alumux2_i_imm;   // address = rs1 + i_imm
                o_ctrl.regfilemux_sel = rf_load;
                o_ctrl.load_regfile   = 1'b1;
                o_ctrl.mem_read       = 1'b1;
                o_ctrl.funct3         = funct3;
            end
            op_store: begin
                o_ctrl.alumux2_sel    = alumux2_s_imm;
                o_ctrl.mem_write      = 1'b1;
                o_ctrl.funct3         = funct3;
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rv32i_pkg::*; (
    input  alu_ops    i_aluop,
    input  rv32i_word i_a,
    input  rv32i_word i_b,
    output rv32i_word o_f,
    output logic      o_cmp
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = i_b[4:0];
    assign lt_s  = $signed(i_a) < $signed(i_b);
    assign lt_u  = i_a < i_b;
    assign o_cmp = (i_aluop == alu_sltu) ? lt_u : lt_s;   // signed unless sltu

    always_comb begin
        case (i_aluop)
            alu_add:  o_f = i_a + i_b;
            alu_sub:  o_f = i_a - i_b;
            alu_sll:  o_f = i_a << shamt;
            alu_slt:  o_f = {31'b0, lt_s};
            alu_sltu: o_f = {31'b0, lt_u};
            alu_xor:  o_f = i_a ^ i_b;
            alu_srl:  o_f = i_a >> shamt;
            alu_sra:  o_f = rv32i_word'($signed(i_a) >>> shamt);
            alu_or:   o_f = i_a | i_b;
            default:  o_f = i_a & i_b;   // alu_and
        endcase
    end

endmodule

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import rv32i_pkg::*; (
    input  logic       clk,
    input  logic       i_rst,
    input  logic       i_we,
    input  logic [4:0] i_rd,
    input  logic [4:0] i_rs1,
    input  logic [4:0] i_rs2,
    input  rv32i_word  i_wdata,
    output rv32i_word  o_rs1_data,
    output rv32i_word  o_rs2_data
);

    rv32i_word regs [1:31];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != 5'd0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    function automatic rv32i_word read_port(input logic [4:0] rs);
        if (rs == 5'd0)
            return '0;
        else if (i_we && rs == i_rd)
            return i_wdata;   // write-through from WB
        else
            return regs[rs];
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1);
        o_rs2_data = read_port(i_rs2);
    end

endmodule

`default_nettype wire

//--- hw/load_store_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_align import rv32i_pkg::*; (
    input  logic [2:0] i_funct3,
    input  logic [1:0] i_addr_lo,
    input  rv32i_word  i_store_data,
    input  rv32i_word  i_load_word,
    output logic [3:0] o_byte_en,
    output rv32i_word  o_wdata,
    output rv32i_word  o_load_data
);

    rv32i_word shifted;   // addressed lane moved down to bit 0

    assign shifted = i_load_word >> {i_addr_lo, 3'b000};

    // store side, data copied into every lane so the enables pick it out
    always_comb begin
        case (i_funct3[1:0])
            2'b00: begin
                o_byte_en = 4'b0001 << i_addr_lo;
                o_wdata   = {4{i_store_data[7:0]}};
            end
            2'b01: begin
                o_byte_en = i_addr_lo[1] ? 4'b1100 : 4'b0011;
                o_wdata   = {2{i_store_data[15:0]}};
            end
            default: begin
                o_byte_en = 4'b1111;   // sw
                o_wdata   = i_store_data;
            end
        endcase
    end

    always_comb begin
        case (i_funct3)
            3'b000:  o_load_data = {{24{shifted[7]}}, shifted[7:0]};     // lb
            3'b100:  o_load_data = {24'b0, shifted[7:0]};                 // lbu
            3'b001:  o_load_data = {{16{shifted[15]}}, shifted[15:0]};   // lh
            3'b101:  o_load_data = {16'b0, shifted[15:0]};                // lhu
            default: o_load_data = i_load_word;                           // lw
        endcase
    end

endmodule

`default_nettype wire

//--- hw/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import rv32i_pkg::*; #(
    parameter rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       i_rst,

    input  rv32i_word  i_i_mem_rdata,
    output rv32i_word  o_i_mem_address,
    output logic       o_i_mem_read,

    input  rv32i_word  i_d_mem_rdata,
    output rv32i_word  o_d_mem_address,
    output rv32i_word  o_d_mem_wdata,
    output logic       o_d_mem_read,
    output logic       o_d_mem_write,
    output logic [3:0] o_mem_byte_en
);

    rv32i_word   pc;
    rv32i_word   if_id_instr;
    rv32i_word   if_id_pc;
    control_word id_ctrl;
    rv32i_word   rs1_data;
    rv32i_word   rs2_data;
    rv32i_word   i_imm;
    rv32i_word   s_imm;
    rv32i_word   u_imm;
    rv32i_word   id_imm;
    id_ex_t      id_ex;
    rv32i_word   alumux1_out;
    rv32i_word   alumux2_out;
    rv32i_word   alu_out;
    logic        alu_cmp;
    ex_mem_t     ex_mem;
    logic [3:0]  store_be;
    mem_wb_t     mem_wb;
    rv32i_word   load_data;
    rv32i_word   wb_data;

    // IF
    always_ff @(posedge clk) begin
        if (i_rst)
            pc <= RESET_PC;
        else
            pc <= pc + 32'd4;   // no branches, straight-line fetch
    end

    assign o_i_mem_address = pc;
    assign o_i_mem_read    = ~i_rst;

    always_ff @(posedge clk) begin
        if (i_rst)
            if_id_instr <= '0;   // opcode 0 decodes as nop
        else
            if_id_instr <= i_i_mem_rdata;
    end

    always_ff @(posedge clk) begin
        if_id_pc <= pc;
    end

    // ID
    control_unit u_control_unit (
        .i_instr (if_id_instr),
        .o_ctrl  (id_ctrl)
    );

    regfile u_regfile (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_we       (mem_wb.ctrl.load_regfile),
        .i_rd       (mem_wb.rd),
        .i_rs1      (if_id_instr[19:15]),
        .i_rs2      (if_id_instr[24:20]),
        .i_wdata    (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    assign i_imm = {{21{if_id_instr[31]}}, if_id_instr[30:20]};
    assign s_imm = {{21{if_id_instr[31]}}, if_id_instr[30:25], if_id_instr[11:7]};
    assign u_imm = {if_id_instr[31:12], 12'h000};

    always_comb begin
        case (id_ctrl.alumux2_sel)
            alumux2_s_imm: id_imm = s_imm;
            alumux2_u_imm: id_imm = u_imm;
            default:       id_imm = i_imm;   // unused for rs2 ops
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst)
            id_ex <= '0;
        else
            id_ex <= '{ctrl: id_ctrl, pc: if_id_pc, rs1_data: rs1_data,
                       rs2_data: rs2_data, imm: id_imm, u_imm: u_imm,
                       rd: if_id_instr[11:7]};
    end

    // EX
    assign alumux1_out = (id_ex.ctrl.alumux1_sel == alumux1_pc) ? id_ex.pc : id_ex.rs1_data;
    assign alumux2_out = (id_ex.ctrl.alumux2_sel == alumux2_rs2) ? id_ex.rs2_data : id_ex.imm;

    alu u_alu (
        .i_aluop (id_ex.ctrl.aluop),
        .i_a     (alumux1_out),
        .i_b     (alumux2_out),
        .o_f     (alu_out),
        .o_cmp   (alu_cmp)
    );

    always_ff @(posedge clk) begin
        if (i_rst)
            ex_mem <= '0;
        else
            ex_mem <= '{ctrl: id_ex.ctrl, alu_out: alu_out, cmp: alu_cmp,
                        store_data: id_ex.rs2_data, u_imm: id_ex.u_imm, rd: id_ex.rd};
    end

    // MEM
    load_store_align store_lane (
        .i_funct3     (ex_mem.ctrl.funct3),
        .i_addr_lo    (ex_mem.alu_out[1:0]),
        .i_store_data (ex_mem.store_data),
        .i_load_word  (i_d_mem_rdata),
        .o_byte_en    (store_be),
        .o_wdata      (o_d_mem_wdata),
        .o_load_data  ()
    );

    assign o_d_mem_address = {ex_mem.alu_out[31:2], 2'b00};
    assign o_d_mem_read    = ex_mem.ctrl.mem_read;
    assign o_d_mem_write   = ex_mem.ctrl.mem_write;
    assign o_mem_byte_en   = store_be & {4{ex_mem.ctrl.mem_write}};   // quiet on loads

    always_ff @(posedge clk) begin
        if (i_rst)
            mem_wb <= '0;
        else
            mem_wb <= '{ctrl: ex_mem.ctrl, alu_out: ex_mem.alu_out, cmp: ex_mem.cmp,
                        load_word: i_d_mem_rdata, addr_lo: ex_mem.alu_out[1:0],
                        u_imm: ex_mem.u_imm, rd: ex_mem.rd};
    end

    // WB
    load_store_align load_lane (
        .i_funct3     (mem_wb.ctrl.funct3),
        .i_addr_lo    (mem_wb.addr_lo),
        .i_store_data ('0),
        .i_load_word  (mem_wb.load_word),
        .o_byte_en    (),
        .o_wdata      (),
        .o_load_data  (load_data)
    );

    always_comb begin
        case (mem_wb.ctrl.regfilemux_sel)
            rf_cmp:   wb_data = {31'b0, mem_wb.cmp};
            rf_u_imm: wb_data = mem_wb.u_imm;
            rf_load:  wb_data = load_data;
            default:  wb_data = mem_wb.alu_out;
        endcase
    end

endmodule

`default_nettype wire

//--- include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// preset words for the load tests, 0x100 past the data base
localparam int        LOAD_IDX   = 64;
localparam rv32i_word LOAD_WORD0 = 32'h80F1_7F25;
localparam rv32i_word LOAD_WORD1 = 32'h1234_ABCD;

// each row sits at its own 16-byte slot, three nops behind it
// compute_and_store writes x5 and then stores it to the next result slot
task automatic build_program();
    add_instr(u_type(32'h00002, 1, op_lui));           // x1 = data base
    add_instr(i_type(100, 0, 0, 2, op_imm));           // x2 = 100
    add_instr(i_type(-7, 0, 0, 3, op_imm));            // x3 = -7
    add_instr(i_type(5, 0, 0, 4, op_imm));             // x4 = 5
    add_instr(u_type(32'hA1B2C, 29, op_lui));
    add_instr(i_type(32'h3D4, 29, 0, 29, op_imm));     // x29 = 0xA1B2C3D4

    compute_and_store("addi",  i_type(-100, 3, 0, 5, op_imm), 32'hFFFF_FF95);
    compute_and_store("add",   r_type(0, 3, 2, 0, 5), 32'h0000_005D);
    compute_and_store("sub",   r_type(32, 3, 2, 0, 5), 32'h0000_006B);
    compute_and_store("sub neg", r_type(32, 2, 3, 0, 5), 32'hFFFF_FF95);
    compute_and_store("and",   r_type(0, 3, 2, 7, 5), 32'h0000_0060);
    compute_and_store("or",    r_type(0, 3, 2, 6, 5), 32'hFFFF_FFFD);
    compute_and_store("xor",   r_type(0, 3, 2, 4, 5), 32'hFFFF_FF9D);
    compute_and_store("sll",   r_type(0, 4, 3, 1, 5), 32'hFFFF_FF20);
    compute_and_store("srl",   r_type(0, 4, 3, 5, 5), 32'h07FF_FFFF);
    compute_and_store("sra",   r_type(32, 4, 3, 5, 5), 32'hFFFF_FFFF);
    compute_and_store("andi",  i_type(32'h03C, 2, 7, 5, op_imm), 32'h0000_0024);
    compute_and_store("ori",   i_type(32'h703, 2, 6, 5, op_imm), 32'h0000_0767);
    compute_and_store("xori",  i_type(-1, 3, 4, 5, op_imm), 32'h0000_0006);
    compute_and_store("slli",  i_type(8, 2, 1, 5, op_imm), 32'h0000_6400);
    compute_and_store("srli",  i_type(28, 3, 5, 5, op_imm), 32'h0000_000F);
    compute_and_store("srai",  i_type(32'h401, 3, 5, 5, op_imm), 32'hFFFF_FFFC);

    compute_and_store("slt",   r_type(0, 2, 3, 2, 5), 32'h0000_0001);   // -7 < 100
    compute_and_store("sltu",  r_type(0, 2, 3, 3, 5), 32'h0000_0000);
    compute_and_store("slti",  i_type(-1, 2, 2, 5, op_imm), 32'h0000_0000);
    compute_and_store("slti neg", i_type(-6, 3, 2, 5, op_imm), 32'h0000_0001);
    compute_and_store("sltiu", i_type(-1, 2, 3, 5, op_imm), 32'h0000_0001);
    compute_and_store("sltiu big", i_type(100, 3, 3, 5, op_imm), 32'h0000_0000);
    compute_and_store("lui",   u_type(32'hABCDE, 5, op_lui), 32'hABCD_E000);
    compute_and_store("auipc", u_type(32'h12345, 5, op_auipc),
                      row_pc(n_rows) + 32'h1234_5000);

    compute_and_store("lb +0",  i_type(32'h100, 1, 0, 5, op_load), 32'h0000_0025);
    compute_and_store("lb +1",  i_type(32'h101, 1, 0, 5, op_load), 32'h0000_007F);
    compute_and_store("lb +2",  i_type(32'h102, 1, 0, 5, op_load), 32'hFFFF_FFF1);
    compute_and_store("lb +3",  i_type(32'h103, 1, 0, 5, op_load), 32'hFFFF_FF80);
    compute_and_store("lbu +0", i_type(32'h100, 1, 4, 5, op_load), 32'h0000_0025);
    compute_and_store("lbu +1", i_type(32'h101, 1, 4, 5, op_load), 32'h0000_007F);
    compute_and_store("lbu +2", i_type(32'h102, 1, 4, 5, op_load), 32'h0000_00F1);
    compute_and_store("lbu +3", i_type(32'h103, 1, 4, 5, op_load), 32'h0000_0080);
    compute_and_store("lh +0",  i_type(32'h100, 1, 1, 5, op_load), 32'h0000_7F25);
    compute_and_store("lh +2",  i_type(32'h102, 1, 1, 5, op_load), 32'hFFFF_80F1);
    compute_and_store("lh neg", i_type(32'h104, 1, 1, 5, op_load), 32'hFFFF_ABCD);
    compute_and_store("lhu +0", i_type(32'h100, 1, 5, 5, op_load), 32'h0000_7F25);
    compute_and_store("lhu +2", i_type(32'h102, 1, 5, 5, op_load), 32'h0000_80F1);
    compute_and_store("lhu hi", i_type(32'h106, 1, 5, 5, op_load), 32'h0000_1234);
    compute_and_store("lw",     i_type(32'h104, 1, 2, 5, op_load), 32'h1234_ABCD);
    compute_and_store("lw neg", i_type(32'h100, 1, 2, 5, op_load), 32'h80F1_7F25);

    // sub-word stores of x29, expected data given in the enabled lanes only
    add_row("sb +0", s_type(32'h0C0, 29, 1, 0), 1'b1, 32'h0000_20C0, 32'h0000_00D4, 4'b0001);
    add_row("sb +1", s_type(32'h0C1, 29, 1, 0), 1'b1, 32'h0000_20C0, 32'h0000_D400, 4'b0010);
    add_row("sb +2", s_type(32'h0C2, 29, 1, 0), 1'b1, 32'h0000_20C0, 32'h00D4_0000, 4'b0100);
    add_row("sb +3", s_type(32'h0C3, 29, 1, 0), 1'b1, 32'h0000_20C0, 32'hD400_0000, 4'b1000);
    add_row("sh +0", s_type(32'h0C4, 29, 1, 1), 1'b1, 32'h0000_20C4, 32'h0000_C3D4, 4'b0011);
    add_row("sh +2", s_type(32'h0C6, 29, 1, 1), 1'b1, 32'h0000_20C4, 32'hC3D4_0000, 4'b1100);
endtask

`endif

//--- dv/tb_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module tb_datapath import rv32i_pkg::*; ();

    localparam rv32i_word RESET_PC      = 32'h0000_1000;
    localparam rv32i_word DMEM_BASE     = 32'h0000_2000;
    localparam rv32i_word NOP           = 32'h0000_0013;   // addi x0, x0, 0
    localparam int        IMEM_WORDS    = 512;
    localparam int        DMEM_WORDS    = 128;
    localparam int        MAX_ROWS      = 128;
    localparam int        STORE_TIMEOUT = 200;
    localparam int        STORE_LATENCY = 3;

    logic       clk = 1'b0;
    logic       i_rst = 1'b1;
    rv32i_word  imem_rdata;
    rv32i_word  imem_addr;
    logic       imem_read;
    rv32i_word  dmem_rdata;
    rv32i_word  dmem_addr;
    rv32i_word  dmem_wdata;
    logic       dmem_read;
    logic       dmem_write;
    logic [3:0] byte_en;

    rv32i_word  imem [IMEM_WORDS];
    rv32i_word  dmem [DMEM_WORDS];
    rv32i_word  imem_idx;
    rv32i_word  dmem_idx;
    string      row_name  [MAX_ROWS];
    logic       row_store [MAX_ROWS];
    rv32i_word  row_addr  [MAX_ROWS];
    rv32i_word  row_data  [MAX_ROWS];
    logic [3:0] row_be    [MAX_ROWS];
    int         fetch_cycle [IMEM_WORDS];   // cycle at which each word was fetched
    int         cycle = 0;
    int         n_rows;
    int         slot;   // next sw result slot
    int         n_pass;
    int         n_fail;

    datapath #(.RESET_PC(RESET_PC)) dut (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_i_mem_rdata   (imem_rdata),
        .o_i_mem_address (imem_addr),
        .o_i_mem_read    (imem_read),
        .i_d_mem_rdata   (dmem_rdata),
        .o_d_mem_address (dmem_addr),
        .o_d_mem_wdata   (dmem_wdata),
        .o_d_mem_read    (dmem_read),
        .o_d_mem_write   (dmem_write),
        .o_mem_byte_en   (byte_en)
    );

    always #50 clk = ~clk;

    function automatic rv32i_word r_type(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg};
    endfunction

    function automatic rv32i_word i_type(input int imm, input int rs1, input int f3,
                                         input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic rv32i_word s_type(input int imm, input int rs2, input int rs1,
                                         input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], op_store};
    endfunction

    function automatic rv32i_word u_type(input int imm, input int rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic rv32i_word row_pc(input int n);
        return RESET_PC + 16 * n;
    endfunction

    function automatic rv32i_word lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic add_row(input string name, input rv32i_word instr, input logic has_store,
                           input rv32i_word addr, input rv32i_word data, input logic [3:0] be);
        imem[4 * n_rows]    = instr;   // the three words behind it stay nops
        row_name[n_rows]    = name;
        row_store[n_rows]   = has_store;
        row_addr[n_rows]    = addr;
        row_data[n_rows]    = data;
        row_be[n_rows]      = be;
        n_rows++;
    endtask

    task automatic add_instr(input rv32i_word instr);
        add_row("", instr, 1'b0, '0, '0, 4'b0000);
    endtask

    task automatic compute_and_store(input string name, input rv32i_word instr,
                                     input rv32i_word expected);
        add_instr(instr);
        add_row(name, s_type(4 * slot, 5, 1, 2), 1'b1, DMEM_BASE + 4 * slot, expected, 4'b1111);
        slot++;
    endtask

    `include "tb_program.svh"

    // both memories answer in the same cycle
    assign imem_idx   = (imem_addr - RESET_PC) >> 2;
    assign imem_rdata = (imem_idx < IMEM_WORDS) ? imem[imem_idx[8:0]] : NOP;
    assign dmem_idx   = (dmem_addr - DMEM_BASE) >> 2;
    assign dmem_rdata = (dmem_read && dmem_idx < DMEM_WORDS) ? dmem[dmem_idx[6:0]] : 32'h0;

    always @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= $urandom;
            end
            dmem[LOAD_IDX]     <= LOAD_WORD0;
            dmem[LOAD_IDX + 1] <= LOAD_WORD1;
        end else if (dmem_write && dmem_idx < DMEM_WORDS) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b])
                    dmem[dmem_idx[6:0]][8*b +: 8] <= dmem_wdata[8*b +: 8];
            end
        end
    end

    always @(negedge clk) begin
        if (!i_rst) begin
            if (imem_idx < IMEM_WORDS)
                fetch_cycle[imem_idx[8:0]] <= cycle;
            cycle <= cycle + 1;
        end
    end

    task automatic check_reset_and_fetch();
        int errors;
        errors = 0;
        for (int c = 0; c < 2; c++) begin
            @(negedge clk);
            if (dmem_write || dmem_read || byte_en != 4'b0000 || imem_read) begin
                $display("[FAIL] reset and fetch: strobes in reset expected %b, actual %b",
                         7'b0, {dmem_write, dmem_read, byte_en, imem_read});
                errors++;
            end
        end
        @(posedge clk);
        i_rst <= 1'b0;   // third reset edge seen
        for (int k = 0; k < 6; k++) begin
            @(negedge clk);
            if (imem_addr != RESET_PC + 4 * k) begin
                $display("[FAIL] reset and fetch: fetch address expected %h, actual %h",
                         RESET_PC + 4 * k, imem_addr);
                errors++;
            end
            if (k < 3 && (dmem_write || dmem_read || byte_en != 4'b0000)) begin
                $display("[FAIL] reset and fetch: data strobes at %0d expected %b, actual %b",
                         k, 6'b0, {dmem_write, dmem_read, byte_en});
                errors++;
            end
            if (!imem_read) begin
                $display("[FAIL] reset and fetch: fetch strobe expected 1, actual %b",
                         imem_read);
                errors++;
            end
        end
        if (errors == 0) begin
            $display("[PASS] reset and fetch");
            n_pass++;
        end else begin
            n_fail++;
        end
    endtask

    task automatic check_store(input int r);
        logic      found;
        int        waited;
        int        errors;
        int        latency;
        rv32i_word mask;
        found  = 1'b0;
        waited = 0;
        errors = 0;
        while (!found && waited < STORE_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (dmem_write)
                found = 1'b1;
        end
        if (!found) begin
            $display("[FAIL] %s: no store arrived within %0d cycles", row_name[r], STORE_TIMEOUT);
            n_fail++;
        end else begin
            mask    = lane_mask(row_be[r]);
            latency = cycle - fetch_cycle[4 * r];
            if (dmem_addr != row_addr[r]) begin
                $display("[FAIL] %s: address expected %h, actual %h",
                         row_name[r], row_addr[r], dmem_addr);
                errors++;
            end
            if (byte_en != row_be[r]) begin
                $display("[FAIL] %s: byte enables expected %b, actual %b",
                         row_name[r], row_be[r], byte_en);
                errors++;
            end
            if ((dmem_wdata & mask) != (row_data[r] & mask)) begin
                $display("[FAIL] %s: data expected %h, actual %h",
                         row_name[r], row_data[r] & mask, dmem_wdata & mask);
                errors++;
            end
            if (latency != STORE_LATENCY) begin
                $display("[FAIL] %s: fetch to store cycles expected %0d, actual %0d",
                         row_name[r], STORE_LATENCY, latency);
                errors++;
            end
            if (errors == 0) begin
                $display("[PASS] %s", row_name[r]);
                n_pass++;
            end else begin
                n_fail++;
            end
        end
    endtask

    initial begin
        void'($urandom(93307));
        n_rows = 0;
        slot   = 0;
        n_pass = 0;
        n_fail = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = NOP;
        end
        build_program();

        check_reset_and_fetch();
        for (int r = 0; r < n_rows; r++) begin
            if (row_store[r])
                check_store(r);
        end

        $display("tests: %0d  passed: %0d  failed: %0d", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
hw/rv32i_pkg.sv
hw/control_unit.sv
hw/alu.sv
hw/regfile.sv
hw/load_store_align.sv
hw/datapath.sv
dv/tb_datapath.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the datapath testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timescale 1ns/1ps --top-module tb_datapath \
    -f list.f -Mdir "$BUILD_DIR" -o tb_datapath
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/tb_datapath" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
